//--- common/noise_config.svh
`ifndef NOISE_CONFIG_SVH
`define NOISE_CONFIG_SVH

// pixel width in bits
`define NE_DATA_WIDTH 8

// block size, kept a power of two so the mean is a plain shift
`define NE_LOG2_SAMPLES 4
`define NE_SAMPLES (1 << `NE_LOG2_SAMPLES)

// depth of the ingress buffer, same as the credits the source starts with
`define NE_CREDITS 4

`endif

//--- common/noise_pkg.sv
`include "noise_config.svh"

package noise_pkg;

	typedef logic [`NE_DATA_WIDTH-1:0]     pixel_t;
	typedef logic [2*`NE_DATA_WIDTH-1:0]   stat_t; // mean, variance, noise
	typedef logic [2*`NE_DATA_WIDTH+7:0]   acc_t;  // headroom for block and frame sums

	// one beat on the pixel input
	typedef struct packed {
		logic   frame_first; // first pixel of a frame
		pixel_t pixel;
	} pixel_beat_t;

	// one entry of the replay delay line
	typedef struct packed {
		logic   valid;
		pixel_t pixel;
	} delay_tap_t;

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		STREAM = 2'd1,
		FLUSH  = 2'd2
	} ctrl_state_t;

endpackage

//--- verilog/pixel_ingress.sv
`timescale 1ns/10ps
`include "noise_config.svh"

module pixel_ingress import noise_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  pixel_beat_t in_beat,
	input  logic        in_valid,
	input  logic        pop,
	output pixel_beat_t head,
	output logic        buf_valid,
	output logic        credit_return
);
	localparam int DEPTH = `NE_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	pixel_beat_t      mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [PTR_W:0]   count;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign head      = mem[rd_ptr];
	assign buf_valid = (count != '0);

	always_ff @(posedge clk) begin
		if (in_valid)
			mem[wr_ptr] <= in_beat;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			credit_return <= pop; // one credit back per popped beat
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- verilog/block_mean_unit.sv
`timescale 1ns/10ps
`include "noise_config.svh"

module block_mean_unit import noise_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  pixel_t pixel,
	input  logic   pop,
	output stat_t  mean,
	output logic   mean_valid
);
	logic [`NE_LOG2_SAMPLES-1:0] cnt;
	acc_t                        sum;
	acc_t                        sum_next;

	assign sum_next = sum + acc_t'(pixel);

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt        <= '0;
			sum        <= '0;
			mean_valid <= 1'b0;
		end else begin
			mean_valid <= 1'b0;
			if (pop) begin
				cnt <= cnt + 1'b1;
				if (cnt == '1) begin
					sum        <= '0;
					mean_valid <= 1'b1;
				end else begin
					sum <= sum_next;
				end
			end
		end
	end

	// floor of sum / NE_SAMPLES
	always_ff @(posedge clk) begin
		if (pop && cnt == '1)
			mean <= stat_t'(sum_next >> `NE_LOG2_SAMPLES);
	end

endmodule

//--- verilog/sample_delay_line.sv
`timescale 1ns/10ps
`include "noise_config.svh"

module sample_delay_line import noise_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  delay_tap_t tap_in,
	input  logic       shift,
	output delay_tap_t tap_out
);
	delay_tap_t taps [`NE_SAMPLES];

	// oldest entry, consumed on the shift that pushes it out
	assign tap_out = taps[`NE_SAMPLES-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NE_SAMPLES; i++)
				taps[i] <= '0;
		end else if (shift) begin
			taps[0] <= tap_in;
			for (int i = 1; i < `NE_SAMPLES; i++)
				taps[i] <= taps[i-1];
		end
	end

endmodule

//--- verilog/block_variance_unit.sv
`timescale 1ns/10ps
`include "noise_config.svh"

module block_variance_unit import noise_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  delay_tap_t tap,
	input  logic       shift,
	input  stat_t      mean,
	input  logic       mean_valid,
	output stat_t      variance,
	output logic       var_valid
);
	localparam int W = `NE_DATA_WIDTH;

	stat_t                       mean_q;
	stat_t                       mean_cur;
	logic signed [W:0]           diff;
	logic signed [2*W+1:0]       sq;
	logic [`NE_LOG2_SAMPLES-1:0] cnt;
	acc_t                        acc;
	acc_t                        acc_next;
	logic                        take;

	// first tap of a block may arrive together with its mean
	assign mean_cur = mean_valid ? mean : mean_q;

	assign diff     = $signed({1'b0, tap.pixel}) - $signed({1'b0, mean_cur[W-1:0]});
	assign sq       = diff * diff;
	assign acc_next = acc + acc_t'(sq);
	assign take     = shift && tap.valid;

	always_ff @(posedge clk) begin
		if (mean_valid)
			mean_q <= mean;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt       <= '0;
			acc       <= '0;
			var_valid <= 1'b0;
		end else begin
			var_valid <= 1'b0;
			if (take) begin
				cnt <= cnt + 1'b1;
				if (cnt == '1) begin
					acc       <= '0;
					var_valid <= 1'b1;
				end else begin
					acc <= acc_next;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take && cnt == '1)
			variance <= stat_t'(acc_next >> `NE_LOG2_SAMPLES); // floor of mean square
	end

endmodule

//--- verilog/frame_noise_average.sv
`timescale 1ns/10ps

module frame_noise_average import noise_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  stat_t      variance,
	input  logic       var_valid,
	input  logic       frame_end,
	input  logic [2:0] frame_log2_blocks,
	output stat_t      noise,
	output logic       noise_valid
);
	acc_t sum;
	acc_t total;
	logic pending;   // frame closed, waiting for its last variance
	logic close;

	assign total = sum + acc_t'(variance);
	assign close = var_valid && pending;

	always_ff @(posedge clk) begin
		if (reset) begin
			sum         <= '0;
			pending     <= 1'b0;
			noise_valid <= 1'b0;
		end else begin
			noise_valid <= close;
			if (frame_end)
				pending <= 1'b1;
			if (close) begin
				sum     <= '0;
				pending <= 1'b0;
			end else if (var_valid) begin
				sum <= total;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (close)
			noise <= stat_t'(total >> frame_log2_blocks);
	end

endmodule

//--- noise_estimation/noise_control.sv
`timescale 1ns/10ps
`include "noise_config.svh"

module noise_control import noise_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       head_first,
	input  logic       buf_valid,
	input  logic [2:0] frame_log2_blocks,
	output logic       pop,
	output logic       shift,
	output logic       frame_end
);
	ctrl_state_t                 state;
	logic [`NE_LOG2_SAMPLES-1:0] pix_cnt;   // pixel within block
	logic [`NE_LOG2_SAMPLES-1:0] flush_cnt;
	logic [6:0]                  blk_cnt;   // block within frame
	logic [`NE_LOG2_SAMPLES-1:0] pix_idx;
	logic [6:0]                  blk_idx;
	logic [7:0]                  blocks;
	logic                        block_last, frame_last, flush_done;

	// no pops while the last block of the frame is replayed
	assign pop   = buf_valid && (state != FLUSH);
	assign shift = pop || (state == FLUSH);

	// a frame_first beat starts both counts over
	assign pix_idx = head_first ? '0 : pix_cnt;
	assign blk_idx = head_first ? '0 : blk_cnt;

	assign blocks     = 8'd1 << frame_log2_blocks;
	assign block_last = (pix_idx == '1);
	assign frame_last = pop && block_last && ({1'b0, blk_idx} == blocks - 8'd1);
	assign flush_done = (flush_cnt == '1);

	// raised on the last flush cycle, so the next var_valid closes the frame
	assign frame_end = (state == FLUSH) && flush_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= IDLE;
			pix_cnt   <= '0;
			blk_cnt   <= '0;
			flush_cnt <= '0;
		end else begin
			case (state)
				IDLE, STREAM: begin
					if (pop) begin
						pix_cnt   <= pix_idx + 1'b1; // wraps at block end
						flush_cnt <= '0;
						if (block_last)
							blk_cnt <= frame_last ? '0 : blk_idx + 1'b1;
						else
							blk_cnt <= blk_idx;
						state <= frame_last ? FLUSH : STREAM;
					end
				end
				FLUSH: begin
					flush_cnt <= flush_cnt + 1'b1;
					if (flush_done)
						state <= STREAM;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- noise_estimation/noise_estimation.sv
`timescale 1ns/10ps

module noise_estimation import noise_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  pixel_beat_t in_beat,
	input  logic        in_valid,
	input  logic [2:0]  frame_log2_blocks,
	output logic        credit_return,
	output stat_t       noise,
	output logic        noise_valid
);
	pixel_beat_t head;
	logic        buf_valid;
	logic        pop, shift, frame_end;
	delay_tap_t  tap_in, tap_out;
	stat_t       mean, variance;
	logic        mean_valid, var_valid;

	// a popped pixel enters the delay line as a valid tap, flush shifts carry bubbles
	assign tap_in.valid = pop;
	assign tap_in.pixel = head.pixel;

	pixel_ingress pixel_ingress_i (
		.clk           (clk),
		.reset         (reset),
		.in_beat       (in_beat),
		.in_valid      (in_valid),
		.pop           (pop),
		.head          (head),
		.buf_valid     (buf_valid),
		.credit_return (credit_return)
	);

	noise_control noise_control_i (
		.clk               (clk),
		.reset             (reset),
		.head_first        (head.frame_first),
		.buf_valid         (buf_valid),
		.frame_log2_blocks (frame_log2_blocks),
		.pop               (pop),
		.shift             (shift),
		.frame_end         (frame_end)
	);

	block_mean_unit block_mean_unit_i (
		.clk        (clk),
		.reset      (reset),
		.pixel      (head.pixel),
		.pop        (pop),
		.mean       (mean),
		.mean_valid (mean_valid)
	);

	sample_delay_line sample_delay_line_i (
		.clk     (clk),
		.reset   (reset),
		.tap_in  (tap_in),
		.shift   (shift),
		.tap_out (tap_out)
	);

	block_variance_unit block_variance_unit_i (
		.clk        (clk),
		.reset      (reset),
		.tap        (tap_out),
		.shift      (shift),
		.mean       (mean),
		.mean_valid (mean_valid),
		.variance   (variance),
		.var_valid  (var_valid)
	);

	frame_noise_average frame_noise_average_i (
		.clk               (clk),
		.reset             (reset),
		.variance          (variance),
		.var_valid         (var_valid),
		.frame_end         (frame_end),
		.frame_log2_blocks (frame_log2_blocks),
		.noise             (noise),
		.noise_valid       (noise_valid)
	);

endmodule

//--- verif/noise_estimation_assert.sv
`timescale 1ns/10ps
`include "noise_config.svh"

module noise_estimation_assert import noise_pkg::*; (
	input logic                         clk,
	input logic                         reset,
	input ctrl_state_t                  state,
	input logic                         pop,
	input logic                         in_valid,
	input logic                         credit_return,
	input logic [$clog2(`NE_CREDITS):0] fifo_count,
	input logic                         noise_valid
);
	int flush_run; // flush cycles before the current one

	always_ff @(posedge clk) begin
		if (reset)
			flush_run <= 0;
		else
			flush_run <= (state == FLUSH) ? flush_run + 1 : 0;
	end

	// a beat popped in a flush cycle would show up as a returned credit
	no_pop_in_flush: assert property (@(posedge clk) disable iff (reset)
		(state == FLUSH) |=> !credit_return) else $error("pop during flush");

	no_overflow: assert property (@(posedge clk) disable iff (reset)
		!(in_valid && !pop && fifo_count == `NE_CREDITS)) else $error("ingress buffer overflow");

	single_pulse: assert property (@(posedge clk) disable iff (reset)
		noise_valid |=> !noise_valid) else $error("noise_valid high for two cycles");

	flush_not_long: assert property (@(posedge clk) disable iff (reset)
		(state == FLUSH) |-> (flush_run < `NE_SAMPLES)) else $error("flush too long");

	flush_not_short: assert property (@(posedge clk) disable iff (reset)
		(state != FLUSH && flush_run != 0) |-> (flush_run == `NE_SAMPLES))
		else $error("flush too short");

endmodule

//--- verif/noise_estimation_tb.sv
`timescale 1ns/10ps
`include "noise_config.svh"

module noise_estimation_tb import noise_pkg::*; ();
	logic        clk = 1'b0;
	logic        reset = 1'b1;
	pixel_beat_t in_beat = '0;
	logic        in_valid = 1'b0;
	logic [2:0]  frame_log2_blocks = 3'd0;
	logic        credit_return;
	stat_t       noise;
	logic        noise_valid;

	pixel_t      pixels[$];     // whole stream from the data file
	stat_t       noise_exp[$];  // one value per frame
	pixel_beat_t beat_q[$];
	int          gap_q[$];      // idle cycles after each beat
	stat_t       exp_q[$];
	int          log2_blocks = 0;
	int          credits = `NE_CREDITS;
	int          gap_left = 0;
	int          pulses = 0;
	int          value_errors = 0;
	int          other_errors = 0;
	bit          gapped = 1'b0;
	bit          stopped = 1'b0;

	noise_estimation noise_estimation_i (
		.clk               (clk),
		.reset             (reset),
		.in_beat           (in_beat),
		.in_valid          (in_valid),
		.frame_log2_blocks (frame_log2_blocks),
		.credit_return     (credit_return),
		.noise             (noise),
		.noise_valid       (noise_valid)
	);

	bind noise_estimation noise_estimation_assert noise_estimation_assert_i (
		.clk           (clk),
		.reset         (reset),
		.state         (noise_control_i.state),
		.pop           (pop),
		.in_valid      (in_valid),
		.credit_return (credit_return),
		.fifo_count    (pixel_ingress_i.count),
		.noise_valid   (noise_valid)
	);

	always #20 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			value_errors++;
			$display("[ERROR] %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic read_testdata();
		int    fd;
		int    n;
		int    value;
		string line;
		fd = $fopen("verif/noise_testdata.txt", "r");
		if (fd == 0) begin
			other_errors++;
			stopped = 1'b1;
			$display("could not open the data file verif/noise_testdata.txt");
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 3 || line[0] == "#")
				continue;
			if (line[0] == "L") begin
				n = $sscanf(line, "L %d", log2_blocks);
			end else if (line[0] == "N") begin
				n = $sscanf(line, "N %h", value);
				noise_exp.push_back(stat_t'(value));
			end else if (line[0] == "B" && line.len() >= 2 + 3 * `NE_SAMPLES - 1) begin
				for (int i = 0; i < `NE_SAMPLES; i++) begin
					n = $sscanf(line.substr(2 + 3 * i, 3 + 3 * i), "%h", value);
					pixels.push_back(pixel_t'(value));
				end
			end
		end
		$fclose(fd);
		if (pixels.size() != noise_exp.size() * (1 << log2_blocks) * `NE_SAMPLES) begin
			other_errors++;
			stopped = 1'b1;
			$display("data file does not hold whole frames for its expected values");
		end
	endtask

	// one pass over the stream with frame_first on each frame's first pixel
	task automatic load_stream();
		pixel_beat_t beat;
		int          frame_pixels;
		frame_pixels = (1 << log2_blocks) * `NE_SAMPLES;
		foreach (noise_exp[k])
			exp_q.push_back(noise_exp[k]);
		foreach (pixels[i]) begin
			beat.frame_first = (i % frame_pixels == 0);
			beat.pixel       = pixels[i];
			beat_q.push_back(beat);
			gap_q.push_back(gapped ? int'($urandom_range(3, 0)) : 0);
		end
	endtask

	task automatic wait_results(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (pulses < target && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (pulses < target) begin
			other_errors++;
			stopped = 1'b1;
			$display("timeout: only %0d of %0d noise results arrived", pulses, target);
		end
	endtask

	task automatic wait_credits(input int limit);
		int cycles;
		cycles = 0;
		while (credits != `NE_CREDITS && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (credits != `NE_CREDITS) begin
			other_errors++;
			stopped = 1'b1;
			$display("timeout: %0d of %0d credits came back", credits, `NE_CREDITS);
		end
	endtask

	// credit accounting and beat driving share one process
	always @(posedge clk) begin
		if (reset) begin
			credits  = `NE_CREDITS;
			gap_left = 0;
			in_valid <= 1'b0;
		end else begin
			if (credit_return === 1'b1)
				credits++;
			if (beat_q.size() > 0 && credits > 0 && gap_left == 0) begin
				in_beat  <= beat_q.pop_front();
				in_valid <= 1'b1;
				credits--;
				gap_left = gap_q.pop_front();
			end else begin
				in_valid <= 1'b0;
				if (gap_left > 0)
					gap_left--;
			end
			if (credits < 0 || credits > `NE_CREDITS) begin
				other_errors++;
				$display("credit count left its range, now %0d", credits);
			end
		end
	end

	always @(posedge clk) begin
		if (noise_valid === 1'b1) begin
			pulses++;
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("noise_valid pulsed with no frame outstanding");
			end else begin
				check_value("noise", noise, exp_q.pop_front());
			end
		end
	end

	initial begin
		int limit;
		void'($urandom(32'h9099));
		read_testdata();
		limit = pixels.size() * 8 + 2000;
		repeat (16) @(posedge clk);
		frame_log2_blocks <= 3'(log2_blocks);
		reset             <= 1'b0;
		// back to back first and then the same data with idle gaps
		for (int phase = 0; phase < 2; phase++) begin
			if (!stopped) begin
				@(negedge clk);
				gapped = (phase == 1);
				load_stream();
				wait_results(noise_exp.size() * (phase + 1), limit);
			end
			if (!stopped)
				wait_credits(limit);
		end
		repeat (4 * `NE_SAMPLES) @(negedge clk); // room for a stray pulse
		if (!stopped)
			check_value("noise_valid pulses", pulses, 2 * noise_exp.size());
		$display("wrong values: %0d, other failures: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- verif/noise_testdata.txt
# L: log2 blocks per frame, B: one block of 16 pixels in hex, N: expected noise in hex
L 2
B 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A
B 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A
B 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A
B 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A 5A
N 0000
B 10 30 10 30 10 30 10 30 10 30 10 30 10 30 10 30
B 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F
B 40 44 40 44 40 44 40 44 40 44 40 44 40 44 40 44
B 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
N 0046
B 00 00 00 00 00 00 00 FF 00 00 00 00 00 00 00 00
B 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF
B 0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00
B 30 10 30 10 30 10 30 10 30 10 30 10 30 10 30 10
N 13DD
B 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF
B FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00
B 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF
B FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00
N 3F80
B 0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00
B 44 40 44 40 44 40 44 40 44 40 44 40 44 40 44 40
B FF 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
B 40 44 40 44 40 44 40 44 40 44 40 44 40 44 40 44
N 03BF

//--- list.f
+incdir+common
common/noise_pkg.sv
verilog/pixel_ingress.sv
verilog/block_mean_unit.sv
verilog/sample_delay_line.sv
verilog/block_variance_unit.sv
verilog/frame_noise_average.sv
noise_estimation/noise_control.sv
noise_estimation/noise_estimation.sv
verif/noise_estimation_assert.sv
verif/noise_estimation_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= noise_estimation_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= ERRORS FOUND

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "test failed, see $(LOG)"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
